// File: flist.f
verilog/sys_id_pkg.sv
verilog/dna_reader.sv
verilog/id_regs.sv
verilog/scratch_bank.sv
verilog/bus_split.sv
verilog/bus_join.sv
verilog/sys_id_top.sv
verif/dna_device_model.sv
verif/sys_id_tb.sv

// File: Bender.yml
package:
  name: sys_id

sources:
  # Shared package, compiled before everything else
  - verilog/sys_id_pkg.sv
  # RTL
  - files:
      - verilog/dna_reader.sv
      - verilog/id_regs.sv
      - verilog/scratch_bank.sv
      - verilog/bus_split.sv
      - verilog/bus_join.sv
      - verilog/sys_id_top.sv
  # Verification
  - target: test
    files:
      - verif/dna_device_model.sv
      - verif/sys_id_tb.sv

// File: verif/sys_id_tb.sv
/*
  Testbench for the system identification top level
  Stimulus table, response scoreboard, DNA chip model on the serial pins
*/
`timescale 1ns/100ps

module sys_id_tb;

localparam logic [sys_id_pkg::DNA_W-1:0] SERIAL = 57'h0823456789ABCDE;
localparam int         LATENCY    = 3;    // Host strobe to rsp.ack
localparam int         POLL_MAX   = 80;   // Busy flag polls
localparam int         DRAIN_MAX  = 16;   // Cycles allowed for the last acks
localparam logic       RD         = 1'b0;
localparam logic       WR         = 1'b1;
localparam logic [1:0] SRC_CONST  = 2'd0; // Table data, written or expected
localparam logic [1:0] SRC_LFSR   = 2'd1; // Random write data
localparam logic [1:0] SRC_SHADOW = 2'd2; // Expected from the scratch model
localparam logic [1:0] SRC_ANY    = 2'd3; // Read data not checked

typedef struct packed {
  logic [2:0]  test;
  logic        wr;
  logic [31:0] addr;
  logic [1:0]  src;
  logic [31:0] data;
  logic        err;
} stim_t;

typedef struct packed {
  logic [31:0] rdata;
  logic        chk_data;
  logic        err;
  logic [31:0] due;      // Cycle of the expected ack
} exp_t;

logic                 bus;
logic                 rst_n;
sys_id_pkg::bus_req_t req;
sys_id_pkg::bus_rsp_t rsp;
logic                 dna_clk;
logic                 dna_read;
logic                 dna_shift;
logic                 dna_dout;

stim_t       stim_q [$];
exp_t        exp_q [$];   // Outstanding responses, oldest first
exp_t        head;
logic [31:0] shadow [1:sys_id_pkg::NUM_BANKS][0:3]; // Scratch register model
logic [31:0] lfsr = 32'h81cc_e0c6;
logic [31:0] last_rdata;
logic [31:0] cyc = '0;
int          errors = 0;
int          n_pass = 0;
int          n_fail = 0;

sys_id_top sys_id_top_inst (
  .bus       (bus),
  .rst_n     (rst_n),
  .req       (req),
  .rsp       (rsp),
  .dna_clk   (dna_clk),
  .dna_read  (dna_read),
  .dna_shift (dna_shift),
  .dna_dout  (dna_dout)
);

dna_device_model dna_device_model_inst (
  .dna_clk   (dna_clk),
  .dna_read  (dna_read),
  .dna_shift (dna_shift),
  .serial    (SERIAL),
  .dna_dout  (dna_dout)
);

initial begin
  bus = 1'b0;
  forever #20 bus = ~bus; // 40 ns period
end

always @(posedge bus)
  cyc <= cyc + 1; // Rising edges so far

////////////////////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////////////////////

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] rand_word();
  logic [31:0] w;
  w = '0;
  for (int i = 0; i < 32; i++) begin
    w    = {w[30:0], lfsr[0]};
    lfsr = lfsr_step(lfsr);
  end
  return w;
endfunction

function automatic logic [31:0] slot_addr(input int slot, input int ofs);
  return (slot << sys_id_pkg::SLOT_OFS_W) | ofs;
endfunction

function automatic stim_t entry(input int t, input logic wr, input int slot, input int ofs,
                               input logic [1:0] src, input logic [31:0] data,
                               input logic err);
  return '{test: t[2:0], wr: wr, addr: slot_addr(slot, ofs), src: src, data: data, err: err};
endfunction

task automatic add(input int t, input logic wr, input int slot, input int ofs,
                   input logic [1:0] src, input logic [31:0] data, input logic err);
  stim_q.push_back(entry(t, wr, slot, ofs, src, data, err));
endtask

// Reserved range from 0x10 up reads zero
function automatic logic [31:0] shadow_read(input logic [31:0] addr);
  if (addr[5:4] != 2'b00)
    return '0;
  return shadow[addr[8:6]][addr[3:2]];
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  if (actual !== expected) begin
    $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    errors++;
  end
endtask

////////////////////////////////////////////////////////////////////////////
// Driver and scoreboard
////////////////////////////////////////////////////////////////////////////

task automatic send(input stim_t s);
  exp_t        e;
  logic [31:0] wdata;
  logic [2:0]  slot;
  slot       = s.addr[sys_id_pkg::SLOT_OFS_W +: sys_id_pkg::SLOT_SEL_W];
  wdata      = (s.src == SRC_LFSR) ? rand_word() : s.data;
  e.rdata    = (s.src == SRC_SHADOW) ? shadow_read(s.addr) : s.data;
  e.chk_data = !s.wr && (s.src != SRC_ANY);
  e.err      = s.err;
  @(posedge bus);
  e.due = cyc + 1 + LATENCY; // Counter steps on this same edge
  req <= '{addr: s.addr, wdata: wdata, wen: s.wr, ren: !s.wr};
  exp_q.push_back(e);
  // Only mapped, non-reserved scratch words take writes
  if (s.wr && slot >= 1 && slot <= sys_id_pkg::NUM_BANKS && s.addr[5:4] == 2'b00)
    shadow[slot][s.addr[3:2]] = wdata;
endtask

// Idle the bus and let the pipeline empty
task automatic drain();
  int n;
  @(posedge bus);
  req.wen <= 1'b0;
  req.ren <= 1'b0;
  n = 0;
  while (exp_q.size() != 0 && n < DRAIN_MAX) begin
    @(negedge bus);
    n++;
  end
  if (exp_q.size() != 0) begin
    $display("Timeout: %0d responses never arrived", exp_q.size());
    errors++;
    exp_q.delete();
  end
endtask

// Outputs sampled mid-cycle
always @(negedge bus) begin
  if (rsp.ack) begin
    if (exp_q.size() == 0) begin
      $display("Unexpected ack with no request outstanding");
      errors++;
    end else begin
      head = exp_q.pop_front();
      check_value("rsp.ack cycle", cyc, head.due);
      check_value("rsp.err", rsp.err, head.err);
      if (head.chk_data)
        check_value("rsp.rdata", rsp.rdata, head.rdata);
      last_rdata = rsp.rdata;
    end
  end else if (exp_q.size() != 0 && cyc >= exp_q[0].due) begin
    $display("Missing ack for the request due at cycle %0d", exp_q[0].due);
    errors++;
    head = exp_q.pop_front();
  end
end

// Poll the busy flag in OFS_DNA_HI bit 31
task automatic wait_dna_ready();
  int polls;
  for (polls = 0; polls < POLL_MAX; polls++) begin
    send(entry(1, RD, 0, sys_id_pkg::OFS_DNA_HI, SRC_ANY, '0, 1'b0));
    drain();
    if (!last_rdata[31])
      break;
    repeat (8) @(posedge bus); // Poll spacing
  end
  if (polls == POLL_MAX) begin
    $display("Timeout: DNA readout still busy after %0d polls", POLL_MAX);
    errors++;
  end
endtask

task automatic report(input string name, input int err_start);
  if (errors == err_start) begin
    $display("Test %s: ok", name);
    n_pass++;
  end else begin
    $display("Test %s: failed with %0d errors", name, errors - err_start);
    n_fail++;
  end
endtask

// Entries of one test go out back to back
task automatic run_test(input int t, input string name);
  int err_start;
  err_start = errors;
  if (t == 1)
    wait_dna_ready();
  foreach (stim_q[i])
    if (stim_q[i].test == t)
      send(stim_q[i]);
  drain();
  report(name, err_start);
endtask

////////////////////////////////////////////////////////////////////////////
// Stimulus table
////////////////////////////////////////////////////////////////////////////

task automatic build_table();
  // DNA words, serial split at bit 32, busy clear
  add(1, RD, 0, sys_id_pkg::OFS_DNA_LO, SRC_CONST, SERIAL[31:0], 1'b0);
  add(1, RD, 0, sys_id_pkg::OFS_DNA_HI, SRC_CONST, {7'b0, SERIAL[56:32]}, 1'b0);
  // Constants, then writes that must not stick
  add(2, RD, 0, sys_id_pkg::OFS_ID, SRC_CONST, sys_id_pkg::BOARD_ID, 1'b0);
  add(2, RD, 0, sys_id_pkg::OFS_FUSE, SRC_CONST, sys_id_pkg::USER_FUSE, 1'b0);
  for (int i = 0; i < 5; i++)
    add(2, RD, 0, (i == 4) ? sys_id_pkg::OFS_GITH4 : sys_id_pkg::OFS_GITH0 + 4 * i,
        SRC_CONST, sys_id_pkg::GIT_HASH[32*i +: 32], 1'b0);
  add(2, WR, 0, sys_id_pkg::OFS_ID, SRC_CONST, 32'hFFFF_FFFF, 1'b0);
  add(2, WR, 0, sys_id_pkg::OFS_FUSE, SRC_LFSR, '0, 1'b0);
  add(2, RD, 0, sys_id_pkg::OFS_ID, SRC_CONST, sys_id_pkg::BOARD_ID, 1'b0);
  add(2, RD, 0, sys_id_pkg::OFS_FUSE, SRC_CONST, sys_id_pkg::USER_FUSE, 1'b0);
  add(2, RD, 0, 'h04, SRC_CONST, '0, 1'b0); // Hole reads zero
  // Scratch banks
  add(3, RD, 2, 0, SRC_SHADOW, '0, 1'b0); // Reset value
  for (int b = 1; b <= sys_id_pkg::NUM_BANKS; b++)
    for (int w = 0; w < 4; w++)
      add(3, WR, b, 4 * w, SRC_LFSR, '0, 1'b0);
  add(3, WR, 1, 'h10, SRC_LFSR, '0, 1'b0); // Reserved, ignored
  add(3, WR, 3, 'h3C, SRC_LFSR, '0, 1'b0);
  for (int b = 1; b <= sys_id_pkg::NUM_BANKS; b++)
    for (int w = 0; w < 4; w++)
      add(3, RD, b, 4 * w, SRC_SHADOW, '0, 1'b0);
  add(3, RD, 1, 'h10, SRC_CONST, '0, 1'b0);
  add(3, RD, 3, 'h3C, SRC_CONST, '0, 1'b0);
  // Unmapped slots, then mapped ones without err
  for (int s = sys_id_pkg::NUM_SLOTS; s < (1 << sys_id_pkg::SLOT_SEL_W); s++) begin
    add(4, RD, s, 0, SRC_CONST, '0, 1'b1);
    add(4, WR, s, 4, SRC_LFSR, '0, 1'b1);
  end
  add(4, RD, 1, 0, SRC_SHADOW, '0, 1'b0);
  add(4, WR, 2, 8, SRC_LFSR, '0, 1'b0);
  // Mixed slots on consecutive cycles
  add(5, RD, 0, sys_id_pkg::OFS_ID, SRC_CONST, sys_id_pkg::BOARD_ID, 1'b0);
  add(5, WR, 3, 8, SRC_LFSR, '0, 1'b0);
  add(5, RD, 3, 8, SRC_SHADOW, '0, 1'b0);
  add(5, RD, 6, 0, SRC_CONST, '0, 1'b1);
  add(5, WR, 1, 12, SRC_LFSR, '0, 1'b0);
  add(5, RD, 2, 4, SRC_SHADOW, '0, 1'b0);
  add(5, RD, 0, sys_id_pkg::OFS_GITH4, SRC_CONST, sys_id_pkg::GIT_HASH[159:128], 1'b0);
  add(5, RD, 1, 12, SRC_SHADOW, '0, 1'b0);
endtask

initial begin
  rst_n = 1'b0;
  req   = '0;
  foreach (shadow[b, w])
    shadow[b][w] = '0; // Banks reset to zero
  build_table();
  repeat (2) @(posedge bus);
  rst_n <= 1'b1;
  @(negedge bus);
  check_value("rsp.ack", rsp.ack, 1'b0);
  check_value("rsp.err", rsp.err, 1'b0);
  check_value("dna_read", dna_read, 1'b1);   // Load phase first
  check_value("dna_shift", dna_shift, 1'b0);
  check_value("dna_clk", dna_clk, 1'b0);
  report("reset state", 0);
  run_test(1, "DNA readout");
  run_test(2, "identification words");
  run_test(3, "scratch banks");
  run_test(4, "unmapped slots");
  run_test(5, "latency and pipelining");
  $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
  if (n_fail == 0 && errors == 0)
    $display("Result: PASSED");
  else
    $display("Result: FAILED");
  $finish;
end

endmodule

// File: verif/dna_device_model.sv
/*
  Behavioral device serial number chip
  Loads on a read strobe, shifts out MSB first
*/
`timescale 1ns/100ps

module dna_device_model (
  input  logic                         dna_clk,
  input  logic                         dna_read,
  input  logic                         dna_shift,
  input  logic [sys_id_pkg::DNA_W-1:0] serial,   // Value captured on load
  output logic                         dna_dout
);

logic [sys_id_pkg::DNA_W-1:0] sr = '0; // Internal DNA register

// Load wins over shift
always @(posedge dna_clk) begin
  if (dna_read)
    sr <= serial;
  else if (dna_shift)
    sr <= {sr[sys_id_pkg::DNA_W-2:0], 1'b0}; // Zero fill from the bottom
end

assign dna_dout = sr[sys_id_pkg::DNA_W-1]; // Current MSB

endmodule

// File: verilog/sys_id_top.sv
/*
  System identification top level
  Splitter, identification slot, generated scratch banks and joiner
*/
`timescale 1ns/100ps

module sys_id_top (
  input  logic                 bus,
  input  logic                 rst_n,
  input  sys_id_pkg::bus_req_t req,
  output sys_id_pkg::bus_rsp_t rsp,
  output logic                 dna_clk,
  output logic                 dna_read,
  output logic                 dna_shift,
  input  logic                 dna_dout
);

sys_id_pkg::bus_req_t slot_req [sys_id_pkg::NUM_SLOTS];
sys_id_pkg::bus_rsp_t slot_rsp [sys_id_pkg::NUM_SLOTS];
logic                 miss; // Unmapped request in flight

////////////////////////////////////////////////////////////////////////////
// Request fan-out
////////////////////////////////////////////////////////////////////////////

bus_split bus_split_inst (
  .bus      (bus),
  .rst_n    (rst_n),
  .req      (req),
  .slot_req (slot_req),
  .miss     (miss)
);

// Slot 0
id_regs id_regs_inst (
  .bus       (bus),
  .rst_n     (rst_n),
  .req       (slot_req[0]),
  .rsp       (slot_rsp[0]),
  .dna_clk   (dna_clk),
  .dna_read  (dna_read),
  .dna_shift (dna_shift),
  .dna_dout  (dna_dout)
);

// Slots 1 up
for (genvar b = 0; b < sys_id_pkg::NUM_BANKS; b++) begin : g_bank
  scratch_bank scratch_bank_inst (
    .bus   (bus),
    .rst_n (rst_n),
    .req   (slot_req[b+1]),
    .rsp   (slot_rsp[b+1])
  );
end

////////////////////////////////////////////////////////////////////////////
// Response merge
////////////////////////////////////////////////////////////////////////////

bus_join bus_join_inst (
  .bus      (bus),
  .rst_n    (rst_n),
  .slot_rsp (slot_rsp),
  .miss     (miss),
  .rsp      (rsp)
);

endmodule

// File: verilog/bus_join.sv
/*
  Registered response collector
  Merges slot responses, turns a delayed miss into an error response
*/
`timescale 1ns/100ps

module bus_join (
  input  logic                 bus,
  input  logic                 rst_n,
  input  sys_id_pkg::bus_rsp_t slot_rsp [sys_id_pkg::NUM_SLOTS],
  input  logic                 miss,
  output sys_id_pkg::bus_rsp_t rsp
);

logic [sys_id_pkg::NUM_SLOTS-1:0] acks;
logic [sys_id_pkg::DATA_W-1:0]    sel_data; // Data of the acking slot
logic                             miss_q;   // Lines miss up with slot acks
logic                             ack_q;
logic                             err_q;
logic [sys_id_pkg::DATA_W-1:0]    rdata_q;

// AND-OR mux, at most one slot acks
always_comb begin
  sel_data = '0;
  for (int s = 0; s < sys_id_pkg::NUM_SLOTS; s++) begin
    acks[s] = slot_rsp[s].ack;
    if (slot_rsp[s].ack)
      sel_data = sel_data | slot_rsp[s].rdata;
  end
end

////////////////////////////////////////////////////////////////////////////
// Response stage
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge bus or negedge rst_n) begin
  if (!rst_n) begin
    miss_q <= 1'b0;
    ack_q  <= 1'b0;
    err_q  <= 1'b0;
  end else begin
    miss_q <= miss;
    ack_q  <= (|acks) | miss_q;
    err_q  <= miss_q;
  end
end

always_ff @(posedge bus) begin
  rdata_q <= miss_q ? '0 : sel_data; // Zero data on error
end

always_comb begin
  rsp.rdata = rdata_q;
  rsp.ack   = ack_q;
  rsp.err   = err_q;
end

// Slots answer one request at a time
a_one_ack: assert property (@(posedge bus) disable iff (!rst_n)
  $onehot0(acks));

endmodule

// File: verilog/bus_split.sv
/*
  Registered address decoder
  Fans one request out to the slots, flags unmapped slots as miss
*/
`timescale 1ns/100ps

module bus_split (
  input  logic                 bus,
  input  logic                 rst_n,
  input  sys_id_pkg::bus_req_t req,
  output sys_id_pkg::bus_req_t slot_req [sys_id_pkg::NUM_SLOTS],
  output logic                 miss
);

logic [sys_id_pkg::SLOT_SEL_W-1:0] sel;
logic [sys_id_pkg::NUM_SLOTS-1:0]  sel_hot;  // Decoded slot, zero on a hole
logic [sys_id_pkg::NUM_SLOTS-1:0]  wen_q;
logic [sys_id_pkg::NUM_SLOTS-1:0]  ren_q;
logic [sys_id_pkg::SLOT_OFS_W-1:0] ofs_q;
logic [sys_id_pkg::DATA_W-1:0]     wdata_q;

assign sel = req.addr[sys_id_pkg::SLOT_OFS_W +: sys_id_pkg::SLOT_SEL_W];

always_comb begin
  for (int s = 0; s < sys_id_pkg::NUM_SLOTS; s++)
    sel_hot[s] = (sel == s);
end

////////////////////////////////////////////////////////////////////////////
// Request stage
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge bus or negedge rst_n) begin
  if (!rst_n) begin
    wen_q <= '0;
    ren_q <= '0;
    miss  <= 1'b0;
  end else begin
    wen_q <= sel_hot & {sys_id_pkg::NUM_SLOTS{req.wen}};
    ren_q <= sel_hot & {sys_id_pkg::NUM_SLOTS{req.ren}};
    miss  <= (req.wen | req.ren) & ~(|sel_hot); // Slot past the map
  end
end

// Shared payload, only the strobes are per slot
always_ff @(posedge bus) begin
  if (req.wen | req.ren) begin
    ofs_q   <= req.addr[sys_id_pkg::SLOT_OFS_W-1:0];
    wdata_q <= req.wdata;
  end
end

always_comb begin
  for (int s = 0; s < sys_id_pkg::NUM_SLOTS; s++) begin
    slot_req[s].addr  = {{(sys_id_pkg::ADDR_W-sys_id_pkg::SLOT_OFS_W){1'b0}}, ofs_q};
    slot_req[s].wdata = wdata_q;
    slot_req[s].wen   = wen_q[s];
    slot_req[s].ren   = ren_q[s];
  end
end

a_one_slot: assert property (@(posedge bus) disable iff (!rst_n)
  $onehot0(wen_q | ren_q));
a_miss_alone: assert property (@(posedge bus) disable iff (!rst_n)
  miss |-> ((wen_q | ren_q) == '0));

endmodule

// File: verilog/scratch_bank.sv
/*
  Scratch register slot, four read/write words
*/
`timescale 1ns/100ps

module scratch_bank (
  input  logic                 bus,
  input  logic                 rst_n,
  input  sys_id_pkg::bus_req_t req,
  output sys_id_pkg::bus_rsp_t rsp
);

logic [sys_id_pkg::DATA_W-1:0]    regs [sys_id_pkg::SCR_WORDS];
logic [sys_id_pkg::SCR_IDX_W-1:0] idx;
logic                             rsvd;
logic                             ack_q;
logic [sys_id_pkg::DATA_W-1:0]    rdata_q;

// Word select and reserved range from 0x10 up
assign idx  = req.addr[2 +: sys_id_pkg::SCR_IDX_W];
assign rsvd = |req.addr[sys_id_pkg::SLOT_OFS_W-1:2+sys_id_pkg::SCR_IDX_W];

always_ff @(posedge bus or negedge rst_n) begin
  if (!rst_n) begin
    regs  <= '{default: '0};
    ack_q <= 1'b0;
  end else begin
    ack_q <= req.wen | req.ren; // One ack per strobe
    if (req.wen && !rsvd)
      regs[idx] <= req.wdata;
  end
end

// Read data, zero in the reserved range
always_ff @(posedge bus) begin
  if (req.ren)
    rdata_q <= rsvd ? '0 : regs[idx];
end

always_comb begin
  rsp.rdata = rdata_q;
  rsp.ack   = ack_q;
  rsp.err   = 1'b0;
end

// Host never issues read and write together
a_no_dual_strobe: assert property (@(posedge bus) disable iff (!rst_n)
  !(req.wen && req.ren));

endmodule

// File: verilog/id_regs.sv
/*
  Identification register slot
  Board ID, user fuse, device serial number with busy flag, source hash
*/
`timescale 1ns/100ps

module id_regs (
  input  logic                 bus,
  input  logic                 rst_n,
  input  sys_id_pkg::bus_req_t req,
  output sys_id_pkg::bus_rsp_t rsp,
  output logic                 dna_clk,
  output logic                 dna_read,
  output logic                 dna_shift,
  input  logic                 dna_dout
);

logic [sys_id_pkg::DNA_W-1:0]      dna_value;
logic                              dna_done;
logic [sys_id_pkg::SLOT_OFS_W-1:0] ofs;
logic                              ack_q;
logic [sys_id_pkg::DATA_W-1:0]     rdata_q;

dna_reader dna_reader_inst (
  .bus       (bus),
  .rst_n     (rst_n),
  .dna_dout  (dna_dout),
  .dna_clk   (dna_clk),
  .dna_read  (dna_read),
  .dna_shift (dna_shift),
  .dna_value (dna_value),
  .dna_done  (dna_done)
);

assign ofs = req.addr[sys_id_pkg::SLOT_OFS_W-1:0]; // Already slot-relative

// Ack any strobe, writes are dropped
always_ff @(posedge bus or negedge rst_n) begin
  if (!rst_n)
    ack_q <= 1'b0;
  else
    ack_q <= req.wen | req.ren;
end

////////////////////////////////////////////////////////////////////////////
// Read mux
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge bus) begin
  if (req.ren) begin
    case (ofs)
      sys_id_pkg::OFS_ID:     rdata_q <= sys_id_pkg::BOARD_ID;
      sys_id_pkg::OFS_FUSE:   rdata_q <= sys_id_pkg::USER_FUSE;
      sys_id_pkg::OFS_DNA_LO: rdata_q <= dna_value[31:0];
      sys_id_pkg::OFS_DNA_HI: rdata_q <= {~dna_done,                       // Busy
                                          {(sys_id_pkg::DATA_W - sys_id_pkg::DNA_W
                                            + 31){1'b0}},
                                          dna_value[sys_id_pkg::DNA_W-1:32]};
      sys_id_pkg::OFS_GITH0:  rdata_q <= sys_id_pkg::GIT_HASH[32*0 +: 32];
      sys_id_pkg::OFS_GITH1:  rdata_q <= sys_id_pkg::GIT_HASH[32*1 +: 32];
      sys_id_pkg::OFS_GITH2:  rdata_q <= sys_id_pkg::GIT_HASH[32*2 +: 32];
      sys_id_pkg::OFS_GITH3:  rdata_q <= sys_id_pkg::GIT_HASH[32*3 +: 32];
      sys_id_pkg::OFS_GITH4:  rdata_q <= sys_id_pkg::GIT_HASH[32*4 +: 32];
      default:                rdata_q <= '0; // Holes read zero
    endcase
  end
end

always_comb begin
  rsp.rdata = rdata_q;
  rsp.ack   = ack_q;
  rsp.err   = 1'b0; // Every offset in this slot is mapped
end

// Ack only follows a strobe one cycle earlier
a_ack_after_strobe: assert property (@(posedge bus) disable iff (!rst_n)
  rsp.ack |-> $past(req.wen | req.ren));

endmodule

// File: verilog/dna_reader.sv
/*
  Startup sequencer for the external device serial number chip
  Loads the DNA register, then shifts 57 bits in MSB first
*/
`timescale 1ns/100ps

module dna_reader (
  input  logic                         bus,
  input  logic                         rst_n,
  input  logic                         dna_dout,
  output logic                         dna_clk,
  output logic                         dna_read,
  output logic                         dna_shift,
  output logic [sys_id_pkg::DNA_W-1:0] dna_value,
  output logic                         dna_done
);

logic [sys_id_pkg::DNA_CNT_W-1:0] cnt; // Sequence position
logic                             sample;

// One sample per port clock period, frozen when finished
assign sample = (cnt[sys_id_pkg::DNA_DIV_W-1:0] == '0) && !dna_done;

////////////////////////////////////////////////////////////////////////////
// Port control
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge bus or negedge rst_n) begin
  if (!rst_n) begin
    cnt       <= '0;
    dna_clk   <= 1'b0;
    dna_read  <= 1'b1; // Load from power-up
    dna_shift <= 1'b0;
    dna_done  <= 1'b0;
  end else begin
    if (!dna_done)
      cnt <= cnt + 1'b1; // Stops for good once done

    dna_clk   <= cnt[sys_id_pkg::DNA_DIV_W-1];         // Divided port clock
    dna_read  <= (cnt < sys_id_pkg::DNA_READ_END);     // Load pulse
    dna_shift <= (cnt > sys_id_pkg::DNA_SHIFT_START);  // Shift after load settles

    if (cnt > sys_id_pkg::DNA_DONE_CNT)
      dna_done <= 1'b1;
  end
end

////////////////////////////////////////////////////////////////////////////
// Serial capture
////////////////////////////////////////////////////////////////////////////

// More samples than bits, so early junk falls off the top
always_ff @(posedge bus) begin
  if (sample)
    dna_value <= {dna_value[sys_id_pkg::DNA_W-2:0], dna_dout}; // MSB first
end

endmodule

// File: verilog/sys_id_pkg.sv
/*
  Shared definitions of the system identification subsystem
  Bus request and response structs, address map, identification constants
*/
package sys_id_pkg;

////////////////////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////////////////////

localparam int ADDR_W     = 32;            // Request address width
localparam int DATA_W     = 32;            // Bus data width
localparam int SLOT_OFS_W = 6;             // 64 bytes per slot
localparam int SLOT_SEL_W = 3;             // Slot field above the offset
localparam int NUM_BANKS  = 3;             // Scratch banks
localparam int NUM_SLOTS  = NUM_BANKS + 1; // ID slot plus banks

// Scratch bank layout
localparam int SCR_WORDS = 4;
localparam int SCR_IDX_W = 2; // Word index, offset bits 3:2

////////////////////////////////////////////////////////////////////////////
// Identification values
////////////////////////////////////////////////////////////////////////////

localparam int DNA_W = 57; // Device serial number

localparam logic [DATA_W-1:0] BOARD_ID  = {28'h0, 4'h1}; // Board type 1
localparam logic [DATA_W-1:0] USER_FUSE = 32'h0123_4567;
// Word i sits at bits 32*i up
localparam logic [5*DATA_W-1:0] GIT_HASH =
  160'h9e1c_4b27_d03a_58f6_7c21_e4b9_a06d_3f85_12ce_b7a4;

// DNA port sequencing
localparam int                   DNA_CNT_W       = 9;
localparam int                   DNA_DIV_W       = 3;      // Port clock is count/8
localparam logic [DNA_CNT_W-1:0] DNA_READ_END    = 9'd10;  // Load phase length
localparam logic [DNA_CNT_W-1:0] DNA_SHIFT_START = 9'd18;
localparam logic [DNA_CNT_W-1:0] DNA_DONE_CNT    = 9'd465;

// Identification slot offsets
localparam logic [SLOT_OFS_W-1:0] OFS_ID     = 6'h00;
localparam logic [SLOT_OFS_W-1:0] OFS_FUSE   = 6'h08;
localparam logic [SLOT_OFS_W-1:0] OFS_DNA_LO = 6'h10;
localparam logic [SLOT_OFS_W-1:0] OFS_DNA_HI = 6'h14; // Bit 31 busy
localparam logic [SLOT_OFS_W-1:0] OFS_GITH0  = 6'h20;
localparam logic [SLOT_OFS_W-1:0] OFS_GITH1  = 6'h24;
localparam logic [SLOT_OFS_W-1:0] OFS_GITH2  = 6'h28;
localparam logic [SLOT_OFS_W-1:0] OFS_GITH3  = 6'h2C;
localparam logic [SLOT_OFS_W-1:0] OFS_GITH4  = 6'h3C; // Not contiguous

typedef struct packed {
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              wen;   // One-cycle write strobe
  logic              ren;   // One-cycle read strobe
} bus_req_t;

typedef struct packed {
  logic [DATA_W-1:0] rdata;
  logic              ack;
  logic              err;   // Unmapped slot
} bus_rsp_t;

endpackage
